// ==== hdl/simd_params.svh ====
/* SIMD min/max slice parameters */

`ifndef SIMD_PARAMS_SVH
`define SIMD_PARAMS_SVH

// --------------------------------------------------
// Datapath layout
// --------------------------------------------------
`define SIMD_WIDTH       32  // Full datapath word
`define SIMD_NUM_LANES   4   // One lane per FP8 element

// Register stages in every lane
`define SIMD_PIPE_STAGES 2

// User tag returned with each result
`define SIMD_TAG_WIDTH   4

`endif

// ==== hdl/simd_pkg.sv ====
/* SIMD min/max shared types */

`include "simd_params.svh"

`default_nettype none

package simd_pkg;

  // --------------------------------------------------
  // Datapath types
  // --------------------------------------------------
  typedef logic [`SIMD_WIDTH-1:0]     word_t;
  typedef logic [`SIMD_TAG_WIDTH-1:0] tag_t;
  typedef logic [`SIMD_NUM_LANES-1:0] lane_mask_t;

  // IEEE flags as {NV, DZ, OF, UF, NX}
  typedef logic [4:0] status_t;
  localparam int unsigned STATUS_NV = 4;

  typedef enum logic [1:0] {
    FMT_FP32 = 2'd0,
    FMT_FP16 = 2'd1,
    FMT_FP8  = 2'd2   // E5M2
  } fp_fmt_e;

  typedef enum logic {
    OP_MIN = 1'b0,
    OP_MAX = 1'b1
  } op_e;

  // Packed as {fmt, vectorial, tag}
  typedef logic [$bits(fp_fmt_e)+`SIMD_TAG_WIDTH:0] aux_t;

  // --------------------------------------------------
  // Format helpers
  // --------------------------------------------------
  function automatic int unsigned fmt_width(fp_fmt_e fmt);
    case (fmt)
      FMT_FP16: return 16;
      FMT_FP8:  return 8;
      default:  return 32;
    endcase
  endfunction

  // Quiet NaN with upper bits already boxed
  function automatic word_t canonical_nan(fp_fmt_e fmt);
    case (fmt)
      FMT_FP16: return 32'hffff_7e00;
      FMT_FP8:  return 32'hffff_ff7e;
      default:  return 32'h7fc0_0000;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== hdl/lane_dispatch.sv ====
/* Lane dispatch */

`timescale 1ns/1ns

`include "simd_params.svh"

`default_nettype none

module lane_dispatch (
  input  logic                                  in_valid_i,
  input  simd_pkg::word_t                       operands_a_i,
  input  simd_pkg::word_t                       operands_b_i,
  input  simd_pkg::fp_fmt_e                     fmt_i,
  input  logic                                  vectorial_i,
  output simd_pkg::lane_mask_t                  lane_valid_o,
  output simd_pkg::word_t [`SIMD_NUM_LANES-1:0] lane_a_o,
  output simd_pkg::word_t [`SIMD_NUM_LANES-1:0] lane_b_o
);

  import simd_pkg::*;

  localparam int unsigned NUM_LANES = `SIMD_NUM_LANES;

  // --------------------------------------------------
  // Operand slicing and valid gating
  // --------------------------------------------------
  always_comb begin
    int unsigned elem_w;
    int unsigned offset;

    elem_w = fmt_width(fmt_i);

    for (int unsigned l = 0; l < NUM_LANES; l++) begin
      offset = l * elem_w;

      // Element l lands in the low bits and the lane ignores the rest
      lane_a_o[l] = operands_a_i >> offset;
      lane_b_o[l] = operands_b_i >> offset;

      // Upper lanes only for vectors, and only if the element fits the word
      lane_valid_o[l] = in_valid_i
                        && ((l == 0) || vectorial_i)
                        && (offset < `SIMD_WIDTH);
    end

    // Format codes past FP8 have no lane layout
    assert ($isunknown(in_valid_i) || !in_valid_i
            || (fmt_i inside {FMT_FP32, FMT_FP16, FMT_FP8}))
      else $error("lane_dispatch: strobe with undefined format");
  end

endmodule

`default_nettype wire

// ==== hdl/minmax_lane.sv ====
/* Min/max lane */

`timescale 1ns/1ns

`include "simd_params.svh"

`default_nettype none

module minmax_lane #(
  parameter int unsigned LANE_WIDTH = 32
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  simd_pkg::word_t   a_i,
  input  simd_pkg::word_t   b_i,
  input  simd_pkg::op_e     op_i,
  input  simd_pkg::fp_fmt_e fmt_i,
  input  logic              mask_i,
  input  simd_pkg::aux_t    aux_i,
  output logic              valid_o,
  output simd_pkg::word_t   result_o,
  output simd_pkg::status_t status_o,
  output logic              mask_o,
  output simd_pkg::aux_t    aux_o,
  output logic              busy_o
);

  import simd_pkg::*;

  localparam int unsigned STAGES    = `SIMD_PIPE_STAGES;
  localparam word_t       LANE_MASK = ~(word_t'('1) << LANE_WIDTH);

  word_t                  a_lane, b_lane;   // Operands cut to the lane width
  word_t                  elem_mask;        // Ones over the active format
  logic                   a_sgn, b_sgn;
  logic [`SIMD_WIDTH-2:0] a_mag, b_mag;
  logic                   a_nan, b_nan;
  logic                   a_snan, b_snan;
  logic                   a_lt_b;
  word_t                  res_d;
  status_t                status_d;

  logic    [STAGES-1:0] valid_q;
  word_t   [STAGES-1:0] result_q;
  status_t [STAGES-1:0] status_q;
  logic    [STAGES-1:0] mask_q;
  aux_t    [STAGES-1:0] aux_q;

  // Sign, magnitude and NaN class of one element
  function automatic void classify(
    input  word_t                  x,
    input  fp_fmt_e                fmt,
    output logic                   sgn,
    output logic [`SIMD_WIDTH-2:0] mag,
    output logic                   is_nan,
    output logic                   is_snan
  );
    logic exp_ones;
    logic man_nz;
    logic quiet;

    mag = '0;
    case (fmt)
      FMT_FP16: begin
        sgn       = x[15];
        mag[14:0] = x[14:0];
        exp_ones  = &x[14:10];
        man_nz    = |x[9:0];
        quiet     = x[9];
      end
      FMT_FP8: begin
        sgn      = x[7];
        mag[6:0] = x[6:0];
        exp_ones = &x[6:2];
        man_nz   = |x[1:0];
        quiet    = x[1];
      end
      default: begin
        sgn      = x[31];
        mag      = x[30:0];
        exp_ones = &x[30:23];
        man_nz   = |x[22:0];
        quiet    = x[22];
      end
    endcase
    is_nan  = exp_ones & man_nz;
    is_snan = is_nan & ~quiet;
  endfunction

  // --------------------------------------------------
  // Compare and select
  // --------------------------------------------------
  assign a_lane    = a_i & LANE_MASK;
  assign b_lane    = b_i & LANE_MASK;
  assign elem_mask = ~(word_t'('1) << fmt_width(fmt_i));

  always_comb begin
    classify(a_lane, fmt_i, a_sgn, a_mag, a_nan, a_snan);
    classify(b_lane, fmt_i, b_sgn, b_mag, b_nan, b_snan);
  end

  // Sign-magnitude order, so -0 sorts below +0
  assign a_lt_b = (a_sgn != b_sgn) ? a_sgn :
                  a_sgn            ? (a_mag > b_mag) : (a_mag < b_mag);

  always_comb begin
    status_d            = '0;
    status_d[STATUS_NV] = a_snan | b_snan;

    if (a_nan && b_nan) begin
      res_d = canonical_nan(fmt_i);
    end else if (a_nan) begin
      res_d = b_lane | ~elem_mask;   // NaN operand drops out
    end else if (b_nan) begin
      res_d = a_lane | ~elem_mask;
    end else if ((op_i == OP_MIN) == a_lt_b) begin
      res_d = a_lane | ~elem_mask;
    end else begin
      res_d = b_lane | ~elem_mask;
    end
  end

  // --------------------------------------------------
  // Pipeline
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= valid_i;
      for (int s = 1; s < STAGES; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_q[0] <= res_d;
      status_q[0] <= status_d;
      mask_q[0]   <= mask_i;
      aux_q[0]    <= aux_i;
    end
    for (int s = 1; s < STAGES; s++) begin
      if (valid_q[s-1]) begin  // Only move real items
        result_q[s] <= result_q[s-1];
        status_q[s] <= status_q[s-1];
        mask_q[s]   <= mask_q[s-1];
        aux_q[s]    <= aux_q[s-1];
      end
    end
  end

  assign valid_o  = valid_q[STAGES-1];
  assign result_o = result_q[STAGES-1];
  assign status_o = status_q[STAGES-1];
  assign mask_o   = mask_q[STAGES-1];
  assign aux_o    = aux_q[STAGES-1];
  assign busy_o   = |valid_q;

  // The dispatcher never hands a lane an element wider than itself
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> (fmt_width(fmt_i) <= LANE_WIDTH))
    else $error("minmax_lane: format too wide for %0d-bit lane", LANE_WIDTH);

endmodule

`default_nettype wire

// ==== hdl/result_pack.sv ====
/* Result packing */

`timescale 1ns/1ns

`include "simd_params.svh"

`default_nettype none

module result_pack (
  input  simd_pkg::lane_mask_t                    lane_valid_i,
  input  simd_pkg::word_t   [`SIMD_NUM_LANES-1:0] lane_result_i,
  input  simd_pkg::status_t [`SIMD_NUM_LANES-1:0] lane_status_i,
  input  simd_pkg::lane_mask_t                    lane_mask_i,
  input  simd_pkg::aux_t                          aux_i,
  output logic                                    out_valid_o,
  output simd_pkg::word_t                         result_o,
  output simd_pkg::status_t                       status_o,
  output simd_pkg::tag_t                          tag_o
);

  import simd_pkg::*;

  localparam int unsigned NUM_LANES = `SIMD_NUM_LANES;

  logic [1:0] res_fmt_bits;
  fp_fmt_e    res_fmt;
  logic       res_vec;

  // Lane 0 carries the format, vector flag and tag
  assign {res_fmt_bits, res_vec, tag_o} = aux_i;
  assign res_fmt     = fp_fmt_e'(res_fmt_bits);
  assign out_valid_o = lane_valid_i[0];

  // --------------------------------------------------
  // Assemble word and collapse status
  // --------------------------------------------------
  always_comb begin
    int unsigned elem_w;
    int unsigned offset;
    word_t       elem_mask;
    word_t       packed_word;
    status_t     flags;

    elem_w      = fmt_width(res_fmt);
    elem_mask   = ~(word_t'('1) << elem_w);
    packed_word = '1;   // NaN-box by default
    flags       = '0;

    for (int unsigned l = 0; l < NUM_LANES; l++) begin
      offset = l * elem_w;
      if (lane_valid_i[l] && ((l == 0) || res_vec)) begin
        packed_word = (packed_word & ~(elem_mask << offset))
                      | ((lane_result_i[l] & elem_mask) << offset);
      end
      if (lane_valid_i[l] && lane_mask_i[l]) begin
        flags = flags | lane_status_i[l];  // Masked lanes stay silent
      end
    end

    result_o = packed_word;
    status_o = flags;

    // All lanes share one pipeline depth, so upper lanes never lead lane 0
    assert ($isunknown(lane_valid_i) || lane_valid_i[0]
            || (lane_valid_i[NUM_LANES-1:1] == '0))
      else $error("result_pack: upper lane valid without lane 0");
  end

endmodule

`default_nettype wire

// ==== hdl/simd_minmax_slice.sv ====
/* SIMD min/max slice */

`timescale 1ns/1ns

`include "simd_params.svh"

`default_nettype none

module simd_minmax_slice (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  input  simd_pkg::word_t      operands_a_i,
  input  simd_pkg::word_t      operands_b_i,
  input  simd_pkg::op_e        op_i,
  input  simd_pkg::fp_fmt_e    fmt_i,
  input  logic                 vectorial_i,
  input  simd_pkg::lane_mask_t simd_mask_i,
  input  simd_pkg::tag_t       tag_i,
  output logic                 out_valid_o,
  output simd_pkg::word_t      result_o,
  output simd_pkg::status_t    status_o,
  output simd_pkg::tag_t       tag_o,
  output logic                 busy_o
);

  localparam int unsigned NUM_LANES = `SIMD_NUM_LANES;

  simd_pkg::lane_mask_t               lane_valid_in;
  simd_pkg::word_t   [NUM_LANES-1:0]  lane_a;
  simd_pkg::word_t   [NUM_LANES-1:0]  lane_b;
  simd_pkg::aux_t                     aux_in;

  simd_pkg::lane_mask_t               lane_valid_out;
  simd_pkg::word_t   [NUM_LANES-1:0]  lane_result;
  simd_pkg::status_t [NUM_LANES-1:0]  lane_status;
  simd_pkg::lane_mask_t               lane_mask;
  simd_pkg::aux_t    [NUM_LANES-1:0]  lane_aux;   // Only lane 0 is read
  logic              [NUM_LANES-1:0]  lane_busy;

  assign aux_in = {fmt_i, vectorial_i, tag_i};

  lane_dispatch i_lane_dispatch (
    .in_valid_i   ( in_valid_i    ),
    .operands_a_i ( operands_a_i  ),
    .operands_b_i ( operands_b_i  ),
    .fmt_i        ( fmt_i         ),
    .vectorial_i  ( vectorial_i   ),
    .lane_valid_o ( lane_valid_in ),
    .lane_a_o     ( lane_a        ),
    .lane_b_o     ( lane_b        )
  );

  // --------------------------------------------------
  // Lanes
  // --------------------------------------------------
  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lanes
    // Lane 0 full word, lane 1 half word, the rest one byte
    localparam int unsigned LANE_WIDTH = (l == 0) ? `SIMD_WIDTH     :
                                         (l == 1) ? `SIMD_WIDTH / 2 : `SIMD_WIDTH / 4;

    minmax_lane #(
      .LANE_WIDTH ( LANE_WIDTH )
    ) i_minmax_lane (
      .clk_i    ( clk_i             ),
      .rst_n_i  ( rst_n_i           ),
      .valid_i  ( lane_valid_in[l]  ),
      .a_i      ( lane_a[l]         ),
      .b_i      ( lane_b[l]         ),
      .op_i     ( op_i              ),
      .fmt_i    ( fmt_i             ),
      .mask_i   ( simd_mask_i[l]    ),
      .aux_i    ( aux_in            ),
      .valid_o  ( lane_valid_out[l] ),
      .result_o ( lane_result[l]    ),
      .status_o ( lane_status[l]    ),
      .mask_o   ( lane_mask[l]      ),
      .aux_o    ( lane_aux[l]       ),
      .busy_o   ( lane_busy[l]      )
    );
  end

  result_pack i_result_pack (
    .lane_valid_i  ( lane_valid_out ),
    .lane_result_i ( lane_result    ),
    .lane_status_i ( lane_status    ),
    .lane_mask_i   ( lane_mask      ),
    .aux_i         ( lane_aux[0]    ),
    .out_valid_o   ( out_valid_o    ),
    .result_o      ( result_o       ),
    .status_o      ( status_o       ),
    .tag_o         ( tag_o          )
  );

  assign busy_o = |lane_busy;  // Any item still in flight

endmodule

`default_nettype wire

// ==== dv/tb_checker.sv ====
/* Min/max slice result checker */

`timescale 1ns/1ns

`include "simd_params.svh"

`default_nettype none

module tb_checker (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  input  simd_pkg::word_t   exp_result_i,
  input  simd_pkg::status_t exp_status_i,
  input  simd_pkg::tag_t    exp_tag_i,
  input  logic              out_valid_i,
  input  simd_pkg::word_t   result_i,
  input  simd_pkg::status_t status_i,
  input  simd_pkg::tag_t    tag_i,
  input  logic              busy_i
);

  import simd_pkg::*;

  localparam int unsigned STAGES = `SIMD_PIPE_STAGES;

  word_t       exp_res_q[$];
  status_t     exp_st_q[$];
  tag_t        exp_tag_q[$];
  int unsigned issue_q[$];    // Cycle of each strobe

  int unsigned       cycle;
  int unsigned       num_tests;
  int unsigned       num_failed;
  int unsigned       num_errors;   // Failures outside any test
  int unsigned       num_results;
  int unsigned       num_pending;
  logic [STAGES-1:0] strobe_hist;  // Strobes of the last few cycles
  logic              reset_seen;

  task automatic compare_field(input string name, input word_t got, input word_t exp,
                               inout int unsigned errs);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      errs++;
    end
  endtask

  // --------------------------------------------------
  // Sampled on the falling edge, away from DUT updates
  // --------------------------------------------------
  always @(negedge clk_i) begin
    int unsigned errs;
    int unsigned issued;

    if (!rst_n_i) begin
      cycle       = 0;
      strobe_hist = '0;
      reset_seen  = 1'b0;
    end else begin
      cycle++;
      if (!reset_seen) begin
        reset_seen = 1'b1;
        num_tests++;
        if (out_valid_i !== 1'b0 || busy_i !== 1'b0) begin
          $display("FAIL reset: out_valid_o or busy_o not low after reset");
          num_failed++;
        end else begin
          $display("PASS reset");
        end
      end

      if (busy_i !== |strobe_hist) begin
        $display("ERROR t=%0t busy_o got %b expected %b", $time, busy_i, |strobe_hist);
        num_errors++;
      end

      if (out_valid_i === 1'b1) begin
        if (exp_res_q.size() == 0) begin
          $display("Unexpected result at t=%0t with no operation outstanding", $time);
          num_errors++;
        end else begin
          errs   = 0;
          issued = issue_q.pop_front();
          if (cycle - issued != STAGES) begin
            $display("Result arrived %0d cycles after its strobe instead of %0d",
                     cycle - issued, STAGES);
            errs++;
          end
          compare_field("result_o", result_i, exp_res_q.pop_front(), errs);
          compare_field("status_o", word_t'(status_i), word_t'(exp_st_q.pop_front()), errs);
          compare_field("tag_o", word_t'(tag_i), word_t'(exp_tag_q[0]), errs);
          num_tests++;
          num_results++;
          if (errs != 0) begin
            num_failed++;
            $display("FAIL test %0d tag %h", num_results, exp_tag_q[0]);
          end else begin
            $display("PASS test %0d tag %h", num_results, exp_tag_q[0]);
          end
          void'(exp_tag_q.pop_front());
        end
      end else if (out_valid_i !== 1'b0) begin
        $display("ERROR t=%0t out_valid_o got %b expected 0", $time, out_valid_i);
        num_errors++;
      end

      // Strobe older than the pipeline with no result
      if (issue_q.size() != 0 && cycle - issue_q[0] > STAGES) begin
        $display("Missing result: tag %h never came out", exp_tag_q[0]);
        num_tests++;
        num_results++;
        num_failed++;
        void'(issue_q.pop_front());
        void'(exp_res_q.pop_front());
        void'(exp_st_q.pop_front());
        void'(exp_tag_q.pop_front());
      end

      if (in_valid_i === 1'b1) begin
        exp_res_q.push_back(exp_result_i);
        exp_st_q.push_back(exp_status_i);
        exp_tag_q.push_back(exp_tag_i);
        issue_q.push_back(cycle);
      end
      strobe_hist = (strobe_hist << 1) | STAGES'(in_valid_i === 1'b1);
      num_pending = issue_q.size();
    end
  end

  initial begin
    num_tests   = 0;
    num_failed  = 0;
    num_errors  = 0;
    num_results = 0;
    num_pending = 0;
  end

endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
/* Min/max slice testbench */

`timescale 1ns/1ns

`default_nettype none

module tb_top;

  import simd_pkg::*;

  localparam int unsigned MAX_VECTORS   = 32;
  localparam int unsigned DRAIN_TIMEOUT = 50;

  logic       clk, rst_n, in_valid, vectorial, out_valid, busy;
  word_t      operands_a, operands_b, result, exp_result;
  op_e        op;
  fp_fmt_e    fmt;
  lane_mask_t simd_mask;
  tag_t       tag, tag_out, exp_tag;
  status_t    status, exp_status;

  logic [127:0] vec_mem [MAX_VECTORS];   // {a, b, expected, control}
  logic [31:0]  lfsr_state;
  int unsigned  num_vectors;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int unsigned n, output int unsigned value);
    value = 0;
    repeat (n) begin
      value      = (value << 1) | lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic apply_vector(input logic [127:0] v);
    operands_a = v[127:96];
    operands_b = v[95:64];
    exp_result = v[63:32];
    op         = op_e'(v[28]);
    fmt        = fp_fmt_e'(v[25:24]);
    vectorial  = v[20];
    simd_mask  = v[19:16];
    tag        = v[15:12];
    exp_tag    = v[15:12];
    exp_status = v[8:4];
    in_valid   = 1'b1;
  endtask

  simd_minmax_slice uut (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .in_valid_i   ( in_valid   ),
    .operands_a_i ( operands_a ),
    .operands_b_i ( operands_b ),
    .op_i         ( op         ),
    .fmt_i        ( fmt        ),
    .vectorial_i  ( vectorial  ),
    .simd_mask_i  ( simd_mask  ),
    .tag_i        ( tag        ),
    .out_valid_o  ( out_valid  ),
    .result_o     ( result     ),
    .status_o     ( status     ),
    .tag_o        ( tag_out    ),
    .busy_o       ( busy       )
  );

  tb_checker i_checker (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .in_valid_i   ( in_valid   ),
    .exp_result_i ( exp_result ),
    .exp_status_i ( exp_status ),
    .exp_tag_i    ( exp_tag    ),
    .out_valid_i  ( out_valid  ),
    .result_i     ( result     ),
    .status_i     ( status     ),
    .tag_i        ( tag_out    ),
    .busy_i       ( busy       )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    int unsigned gap;
    int unsigned wait_cycles;

    rst_n      = 1'b0;
    in_valid   = 1'b0;
    operands_a = '0;
    operands_b = '0;
    op         = OP_MIN;
    fmt        = FMT_FP32;
    vectorial  = 1'b0;
    simd_mask  = '0;
    tag        = '0;
    exp_result = '0;
    exp_status = '0;
    exp_tag    = '0;
    lfsr_state = 32'h9c2e_b94a;

    for (int i = 0; i < MAX_VECTORS; i++) begin
      vec_mem[i] = '1;   // Marks unused entries
    end
    $readmemh("dv/minmax_testdata.hex", vec_mem);
    num_vectors = 0;
    while (num_vectors < MAX_VECTORS && vec_mem[num_vectors] !== '1) begin
      num_vectors++;
    end

    repeat (4) next_cycle();
    rst_n = 1'b1;
    next_cycle();

    for (int unsigned i = 0; i < num_vectors; i++) begin
      if (i % 2 == 0) begin
        take_bits(2, gap);
      end else begin
        gap = 0;   // Odd vectors follow back to back
      end
      if (gap != 0) begin
        in_valid = 1'b0;
        repeat (gap) next_cycle();
      end
      apply_vector(vec_mem[i]);
      next_cycle();
    end
    in_valid = 1'b0;

    wait_cycles = 0;
    while ((i_checker.num_results < num_vectors || i_checker.num_pending != 0
            || busy !== 1'b0) && wait_cycles < DRAIN_TIMEOUT) begin
      next_cycle();
      wait_cycles++;
    end

    if (wait_cycles >= DRAIN_TIMEOUT) begin
      $display("Timeout: results still outstanding after %0d cycles", DRAIN_TIMEOUT);
      $display("SOME TESTS FAILED");
    end else begin
      if (i_checker.num_results != num_vectors) begin
        $display("Got %0d results for %0d vectors", i_checker.num_results, num_vectors);
      end
      $display("Tests run %0d, failed %0d, other errors %0d",
               i_checker.num_tests, i_checker.num_failed, i_checker.num_errors);
      if (num_vectors != 0 && i_checker.num_results == num_vectors
          && i_checker.num_failed == 0 && i_checker.num_errors == 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hdl
hdl/simd_pkg.sv
hdl/lane_dispatch.sv
hdl/minmax_lane.sv
hdl/result_pack.sv
hdl/simd_minmax_slice.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SIMD min/max slice testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal \
  -f build.f \
  --top-module tb_top \
  -o tb_top_sim

./obj_dir/tb_top_sim > sim.log
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
exit 1

// ==== dv/minmax_testdata.hex ====
// operand_a _ operand_b _ expected_result _ {op, fmt, vectorial, mask, tag, status[7:0], 0}
// op 0 min / 1 max, fmt 0 FP32 / 1 FP16 / 2 FP8, status 10 means NV
3f800000_40000000_3f800000_000f0000
3f800000_40000000_40000000_100f1000
c0400000_3f800000_c0400000_000f2000
bf800000_c0000000_bf800000_100f3000
80000000_00000000_00000000_100f4000
80000000_00000000_80000000_000f5000
7fc00000_40a00000_40a00000_000f6000
7f800001_c1200000_c1200000_100f7100
7fc00001_ffc00000_7fc00000_000f8000
3c00c000_4000bc00_3c00c000_011f9000
7e000000_42008000_42000000_111fa000
12343c00_56784000_ffff3c00_010fb000
00007e01_0000fe00_ffff7e00_010fc000
3cc04438_40bc387e_3cc03838_021fd000
3cc04438_40bc387e_40bc4438_121fe000
aabbcc3c_11223340_ffffff3c_020ff000
3c7d3c3c_40404040_40404040_121f0100
3c7d3c3c_40404040_40404040_121b1000
007d0038_00000040_ffffff38_020f2000
0000007d_00000000_00000000_021e3000
7d013c00_40004000_40003c00_01124100
7f800001_3f800000_3f800000_000e5000
